// File: sources.f
+incdir+source
source/spi_wb_pkg.sv
source/wb_if.sv
source/spi_wb_bridge.sv
source/wb_slave_decoder.sv
source/wb_reg_slot.sv
source/wb_resp_collector.sv
source/spi_wb_top.sv
verification/spi_wb_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := spi_wb_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HEADERS := $(wildcard source/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) verification/spi_wb_trace.txt
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/spi_wb_trace.txt
// columns: op (1 write, 0 read), sel, word address, write data,
// expected status byte, expected read data. op ff ends the trace.
0 f 00000000 00000000 01 51070000
0 f 00000100 00000000 01 51070001
0 f 00000200 00000000 01 51070002
0 f 00000300 00000000 01 51070003
1 f 00000001 a5a5a5a5 01 00000000
1 3 00000001 11223344 01 00000000
0 f 00000001 00000000 01 a5a53344
1 8 00000001 99887766 01 00000000
0 f 00000001 00000000 01 99a53344
1 6 00000101 deadbeef 01 00000000
0 f 00000101 00000000 01 00adbe00
0 f 00000201 00000000 01 00000000
// illegal accesses
1 f 00000000 12345678 02 00000000
1 f 00000003 00000001 02 00000000
0 f 00000004 00000000 02 00000000
1 f 00000109 ffffffff 02 00000000
0 f 00000000 00000000 01 51070000
// nobody answers
0 f 00000400 00000000 06 00000000
1 f 00000f01 12345678 06 00000000
0 f 00010001 00000000 06 00000000
// control and write counts
1 1 00000002 00000001 01 00000000
0 f 00000002 00000000 01 00000001
0 f 00000003 00000000 01 00000004
0 f 00000103 00000000 01 00000001
1 1 00000002 fffffffe 01 00000000
0 f 00000002 00000000 01 000000fe
0 f 00000003 00000000 01 00000005
0 f 00000203 00000000 01 00000000
ff 0 00000000 00000000 00 00000000

// File: verification/spi_wb_tb.sv
`timescale 1ns/10ps

module spi_wb_tb;

  localparam int MAX_REC    = 64;
  localparam int BYTE_GAP   = 16;     // sclk idle cycles before each byte.
  localparam int PULSE_WAIT = 40;
  localparam int LCG_LOOPS  = 8;

  logic        sys_clk;
  logic        arst_n_i;
  logic        spi_cs_n;
  logic        spi_sclk;
  logic        spi_mosi;
  logic        spi_miso;
  logic        cmd_stb;
  logic        debug_led;

  logic [31:0] trace_mem [MAX_REC*6];
  int          pulse_cnt = 0;
  int          frame_cnt;
  logic        led_model;

  spi_wb_top u_dut (
    .sys_clk     (sys_clk),
    .arst_n_i    (arst_n_i),
    .spi_cs_n_i  (spi_cs_n),
    .spi_sclk_i  (spi_sclk),
    .spi_mosi_i  (spi_mosi),
    .spi_miso_o  (spi_miso),
    .cmd_stb_o   (cmd_stb),
    .debug_led_o (debug_led)
  );

  initial begin
    sys_clk = 1'b0;
    forever #10 sys_clk = ~sys_clk;
  end

  always @(negedge sys_clk) begin
    if (cmd_stb) begin
      pulse_cnt <= pulse_cnt + 1;     // one count per pulse cycle.
    end
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  task automatic tick(input int n);
    repeat (n) begin
      @(posedge sys_clk);
      #2;
    end
  endtask

  task automatic stop_on_error();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR %0t ns %s got %08h expected %08h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] apply_sel(input logic [31:0] old_val,
                                            input logic [31:0] new_val,
                                            input logic [3:0]  sel);
    logic [31:0] mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  // mode 0 with miso taken at the rising sclk.
  task automatic spi_bit(input logic tx, output logic rx);
    spi_mosi = tx;
    tick(4);
    spi_sclk = 1'b1;
    rx = spi_miso;
    tick(4);
    spi_sclk = 1'b0;
  endtask

  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    tick(BYTE_GAP);
    for (int b = 7; b >= 0; b--) begin
      spi_bit(tx[b], rx[b]);
    end
  endtask

  task automatic spi_frame(input logic we, input logic [3:0] sel, input logic [31:0] adr,
                           input logic [31:0] wdat, output logic [7:0] status,
                           output logic [31:0] rdat);
    logic [7:0] rx;
    spi_cs_n = 1'b0;
    rdat = '0;
    spi_byte({we, 3'b000, sel}, rx);
    for (int k = 3; k >= 0; k--) begin
      spi_byte(adr[8*k +: 8], rx);
    end
    if (we) begin
      for (int k = 3; k >= 0; k--) begin
        spi_byte(wdat[8*k +: 8], rx);
      end
    end
    spi_byte(8'h00, status);
    if (!we) begin
      for (int k = 3; k >= 0; k--) begin
        spi_byte(8'h00, rx);
        rdat[8*k +: 8] = rx;
      end
    end
    tick(4);
    spi_cs_n = 1'b1;
  endtask

  task automatic run_check(input logic we, input logic [3:0] sel, input logic [31:0] adr,
                           input logic [31:0] wdat, input logic [7:0] exp_st,
                           input logic [31:0] exp_rd);
    logic [7:0]  status;
    logic [31:0] rdat;
    int          waited;
    frame_cnt++;
    spi_frame(we, sel, adr, wdat, status, rdat);
    waited = 0;
    while (pulse_cnt != frame_cnt && waited < PULSE_WAIT) begin
      tick(1);
      waited++;
    end
    assert (pulse_cnt == frame_cnt) else begin
      $display("ERROR %0t ns no cmd_stb_o pulse after frame %0d", $time, frame_cnt);
      stop_on_error();
    end
    tick(8);
    check_val("cmd_stb_o pulse count", 32'(pulse_cnt), 32'(frame_cnt));
    check_val("spi_miso_o status", {24'h0, status}, {24'h0, exp_st});
    if (!we) begin
      check_val("spi_miso_o read data", rdat, exp_rd);
    end
    if (we && adr == 32'h2 && sel[0] && exp_st == 8'h01) begin
      led_model = wdat[0];            // slot 0 control bit 0.
    end
    check_val("debug_led_o", {31'h0, debug_led}, {31'h0, led_model});
  endtask

  task automatic short_toggle();
    logic rx;
    spi_cs_n = 1'b0;
    tick(4);
    for (int b = 0; b < 7; b++) begin
      spi_bit(1'b1, rx);
    end
    spi_cs_n = 1'b1;
    tick(PULSE_WAIT);
    check_val("cmd_stb_o pulse count", 32'(pulse_cnt), 32'(frame_cnt));
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    logic [31:0] lcg_state;
    logic [31:0] model;
    logic [31:0] wdat;
    logic [3:0]  sel;
    arst_n_i  = 1'b0;
    spi_cs_n  = 1'b1;
    spi_sclk  = 1'b0;
    spi_mosi  = 1'b0;
    led_model = 1'b0;
    frame_cnt = 0;
    $readmemh("verification/spi_wb_trace.txt", trace_mem);
    repeat (2) @(posedge sys_clk);
    #2;
    arst_n_i = 1'b1;
    tick(4);

    for (int r = 0; r < MAX_REC; r++) begin
      if (trace_mem[6*r] == 32'hff) begin
        break;
      end
      run_check(trace_mem[6*r][0], trace_mem[6*r+1][3:0], trace_mem[6*r+2],
                trace_mem[6*r+3], trace_mem[6*r+4][7:0], trace_mem[6*r+5]);
    end

    short_toggle();

    // slot 3 scratch is left alone by the trace.
    lcg_state = 32'd66;
    model     = '0;
    for (int n = 0; n < LCG_LOOPS; n++) begin
      lcg_state = lcg_next(lcg_state);
      wdat      = lcg_state;
      lcg_state = lcg_next(lcg_state);
      sel       = lcg_state[19:16];
      model     = apply_sel(model, wdat, sel);
      run_check(1'b1, sel, 32'h301, wdat, 8'h01, 32'h0);
      run_check(1'b0, 4'hf, 32'h301, 32'h0, 8'h01, model);
    end
    run_check(1'b0, 4'hf, 32'h303, 32'h0, 8'h01, 32'(LCG_LOOPS));

    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: source/spi_wb_top.sv
`timescale 1ns/10ps
`include "spi_wb_macros.svh"

module spi_wb_top (
  input  logic sys_clk,
  input  logic arst_n_i,
  input  logic spi_cs_n_i,
  input  logic spi_sclk_i,
  input  logic spi_mosi_i,
  output logic spi_miso_o,
  output logic cmd_stb_o,
  output logic debug_led_o
);

  logic [`SPI_WB_N_SLOTS-1:0] slot_debug;

  wb_if m_bus ();
  wb_if s_bus [`SPI_WB_N_SLOTS] ();

  // ----------------------------------------------------------------------
  // spi side
  // ----------------------------------------------------------------------
  spi_wb_bridge u_bridge (
    .sys_clk    (sys_clk),
    .arst_n_i   (arst_n_i),
    .spi_cs_n_i (spi_cs_n_i),
    .spi_sclk_i (spi_sclk_i),
    .spi_mosi_i (spi_mosi_i),
    .spi_miso_o (spi_miso_o),
    .cmd_stb_o  (cmd_stb_o),
    .m_bus      (m_bus)
  );

  // ----------------------------------------------------------------------
  // bus fabric and register slots
  // ----------------------------------------------------------------------
  wb_slave_decoder u_decoder (
    .m_bus (m_bus),
    .s_bus (s_bus)
  );

  for (genvar i = 0; i < `SPI_WB_N_SLOTS; i++) begin : g_slot
    wb_reg_slot #(
      .SLOT_ID (i)
    ) u_slot (
      .sys_clk  (sys_clk),
      .arst_n_i (arst_n_i),
      .bus      (s_bus[i]),
      .debug_o  (slot_debug[i])
    );
  end

  wb_resp_collector u_collector (
    .sys_clk  (sys_clk),
    .arst_n_i (arst_n_i),
    .s_bus    (s_bus),
    .m_bus    (m_bus)
  );

  assign debug_led_o = slot_debug[0];   // slot 0 control bit 0.

endmodule

// File: source/wb_resp_collector.sv
`timescale 1ns/10ps
`include "spi_wb_macros.svh"

module wb_resp_collector (
  input  logic   sys_clk,
  input  logic   arst_n_i,
  wb_if.observer s_bus [`SPI_WB_N_SLOTS],
  wb_if.target   m_bus
);

  localparam int CNT_W = $clog2(`SPI_WB_TIMEOUT) + 1;

  logic [`SPI_WB_N_SLOTS-1:0] ack_v;
  logic [`SPI_WB_N_SLOTS-1:0] err_v;
  logic [31:0]                dat_v [`SPI_WB_N_SLOTS];
  logic [31:0]                dat_sel;
  logic                       any_resp;
  logic                       fire;
  logic [CNT_W-1:0]           to_cnt_q;
  logic                       ack_q;
  logic                       err_q;
  logic [31:0]                dat_q;

  for (genvar i = 0; i < `SPI_WB_N_SLOTS; i++) begin : g_tap
    assign ack_v[i] = s_bus[i].ack;
    assign err_v[i] = s_bus[i].err;
    assign dat_v[i] = s_bus[i].dat_r;
  end

  always_comb begin
    dat_sel = '0;
    for (int k = 0; k < `SPI_WB_N_SLOTS; k++) begin
      if (ack_v[k]) begin
        dat_sel = dat_v[k];
      end
    end
  end

  // ----------------------------------------------------------------------
  // watchdog for addresses nobody answers
  // ----------------------------------------------------------------------
  assign any_resp = (|ack_v) || (|err_v) || m_bus.ack || m_bus.err;
  assign fire     = m_bus.stb && !any_resp && (to_cnt_q == CNT_W'(`SPI_WB_TIMEOUT - 1));

  always_ff @(posedge sys_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      to_cnt_q <= '0;
      ack_q    <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      ack_q <= |ack_v;
      err_q <= (|err_v) || fire;
      if (!m_bus.stb) begin
        to_cnt_q <= '0;
      end else if (!any_resp && (to_cnt_q != CNT_W'(`SPI_WB_TIMEOUT))) begin
        to_cnt_q <= to_cnt_q + 1'b1;    // saturates, fires once.
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    dat_q <= dat_sel;
  end

  assign m_bus.ack   = ack_q;
  assign m_bus.err   = err_q;
  assign m_bus.dat_r = dat_q;

endmodule

// File: source/wb_reg_slot.sv
`timescale 1ns/10ps
`include "spi_wb_macros.svh"

module wb_reg_slot #(
  parameter int SLOT_ID = 0
) (
  input  logic sys_clk,
  input  logic arst_n_i,
  wb_if.target bus,
  output logic debug_o
);

  localparam logic [31:0] ID_VALUE = 32'h5107_0000 + SLOT_ID;

  localparam logic [`SPI_WB_REG_W-1:0] REG_ID      = `SPI_WB_REG_W'(0);
  localparam logic [`SPI_WB_REG_W-1:0] REG_SCRATCH = `SPI_WB_REG_W'(1);
  localparam logic [`SPI_WB_REG_W-1:0] REG_CTRL    = `SPI_WB_REG_W'(2);
  localparam logic [`SPI_WB_REG_W-1:0] REG_WCNT    = `SPI_WB_REG_W'(3);

  logic [`SPI_WB_REG_W-1:0] reg_idx;
  logic [31:0]              scratch_q;
  logic [31:0]              ctrl_q;
  logic [31:0]              wcnt_q;
  logic [31:0]              rd_val;
  logic [31:0]              dat_r_q;
  logic                     legal;
  logic                     take;
  logic                     served_q;
  logic                     ack_q;
  logic                     err_q;

  function automatic logic [31:0] byte_merge(input logic [31:0] old_val,
                                             input logic [31:0] new_val,
                                             input logic [3:0]  sel);
    logic [31:0] res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign reg_idx = bus.adr.f.reg_idx;
  assign take    = bus.cyc && bus.stb && !served_q;   // once per strobe.

  always_comb begin
    legal  = 1'b1;
    rd_val = '0;
    case (reg_idx)
      REG_ID: begin
        rd_val = ID_VALUE;
        legal  = !bus.we;
      end
      REG_SCRATCH: rd_val = scratch_q;
      REG_CTRL:    rd_val = ctrl_q;
      REG_WCNT: begin
        rd_val = wcnt_q;
        legal  = !bus.we;
      end
      default: legal = 1'b0;
    endcase
  end

  always_ff @(posedge sys_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      served_q  <= 1'b0;
      ack_q     <= 1'b0;
      err_q     <= 1'b0;
      scratch_q <= '0;
      ctrl_q    <= '0;
      wcnt_q    <= '0;
    end else begin
      ack_q    <= take && legal;
      err_q    <= take && !legal;
      served_q <= bus.cyc && bus.stb;
      if (take && legal && bus.we) begin
        wcnt_q <= wcnt_q + 1'b1;
        if (reg_idx == REG_SCRATCH) begin
          scratch_q <= byte_merge(scratch_q, bus.dat_w, bus.sel);
        end
        if (reg_idx == REG_CTRL) begin
          ctrl_q <= byte_merge(ctrl_q, bus.dat_w, bus.sel);
        end
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (take) begin
      dat_r_q <= (legal && !bus.we) ? rd_val : '0;
    end
  end

  assign bus.ack   = ack_q;
  assign bus.err   = err_q;
  assign bus.dat_r = dat_r_q;
  assign debug_o   = ctrl_q[0];

endmodule

// File: source/wb_slave_decoder.sv
`timescale 1ns/10ps
`include "spi_wb_macros.svh"

module wb_slave_decoder (
  wb_if.target    m_bus,
  wb_if.initiator s_bus [`SPI_WB_N_SLOTS]
);

  spi_wb_pkg::wb_addr_u adr;
  logic                 pad_zero;

  assign adr      = m_bus.adr;
  assign pad_zero = (adr.f.pad == '0);   // anything above the slot field misses.

  // ----------------------------------------------------------------------
  // per-slot routing
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < `SPI_WB_N_SLOTS; i++) begin : g_route
    logic hit;

    assign hit = pad_zero && (adr.f.slot == `SPI_WB_SLOT_W'(i));

    // strobes only to the addressed slot.
    assign s_bus[i].cyc   = m_bus.cyc && hit;
    assign s_bus[i].stb   = m_bus.stb && hit;

    // request payload is broadcast.
    assign s_bus[i].we    = m_bus.we;
    assign s_bus[i].sel   = m_bus.sel;
    assign s_bus[i].adr   = m_bus.adr;
    assign s_bus[i].dat_w = m_bus.dat_w;
  end

endmodule

// File: source/spi_wb_bridge.sv
`timescale 1ns/10ps
`include "spi_wb_macros.svh"

module spi_wb_bridge (
  input  logic    sys_clk,
  input  logic    arst_n_i,
  input  logic    spi_cs_n_i,
  input  logic    spi_sclk_i,
  input  logic    spi_mosi_i,
  output logic    spi_miso_o,
  output logic    cmd_stb_o,
  wb_if.initiator m_bus
);

  localparam int BIT_CNT_W = $clog2(`SPI_WB_ADDR_END + `SPI_WB_TX_W + 1);
  localparam int WAIT_W    = $clog2(`SPI_WB_TIMEOUT) + 1;

  logic [2:0]                 sclk_sr;
  logic [2:0]                 cs_sr;
  logic [1:0]                 mosi_sr;
  logic                       sclk_rise;
  logic                       sclk_fall;
  logic                       cs_rise;
  logic                       cs_n_s;
  logic                       mosi_s;

  logic [BIT_CNT_W-1:0]       bit_cnt_q;
  logic [BIT_CNT_W-1:0]       tx_start;
  logic [31:0]                rx_sr_q;
  logic [31:0]                rx_word;
  logic [7:0]                 cmd_q;
  spi_wb_pkg::wb_addr_u       adr_q;
  logic [31:0]                dat_w_q;
  logic                       launch;

  logic                       stb_q;
  logic                       resp;
  logic [WAIT_W-1:0]          wait_q;
  spi_wb_pkg::wb_status_t     status;
  logic [`SPI_WB_TX_W-1:0]    tx_sr_q;

  // ----------------------------------------------------------------------
  // pin synchronizers and edge detect
  // ----------------------------------------------------------------------
  always_ff @(posedge sys_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sclk_sr <= '0;
      cs_sr   <= '1;      // deselected.
      mosi_sr <= '0;
    end else begin
      sclk_sr <= {sclk_sr[1:0], spi_sclk_i};
      cs_sr   <= {cs_sr[1:0], spi_cs_n_i};
      mosi_sr <= {mosi_sr[0], spi_mosi_i};
    end
  end

  assign sclk_rise = sclk_sr[1] & ~sclk_sr[2];
  assign sclk_fall = ~sclk_sr[1] & sclk_sr[2];
  assign cs_n_s    = cs_sr[1];
  assign cs_rise   = cs_sr[1] & ~cs_sr[2];
  assign mosi_s    = mosi_sr[1];

  // ----------------------------------------------------------------------
  // receive side
  // ----------------------------------------------------------------------
  assign rx_word  = {rx_sr_q[30:0], mosi_s};
  assign tx_start = cmd_q[7] ? BIT_CNT_W'(`SPI_WB_DATA_END) : BIT_CNT_W'(`SPI_WB_ADDR_END);

  // last address bit of a read, last data bit of a write.
  assign launch = sclk_rise && !cs_n_s &&
                  (cmd_q[7] ? (bit_cnt_q == BIT_CNT_W'(`SPI_WB_DATA_END - 1))
                            : (bit_cnt_q == BIT_CNT_W'(`SPI_WB_ADDR_END - 1)));

  always_ff @(posedge sys_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bit_cnt_q <= '0;
      cmd_stb_o <= 1'b0;
    end else begin
      cmd_stb_o <= cs_rise && (bit_cnt_q >= BIT_CNT_W'(`SPI_WB_CMD_END));
      if (cs_n_s) begin
        bit_cnt_q <= '0;
      end else if (sclk_rise) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (sclk_rise && !cs_n_s) begin
      rx_sr_q <= rx_word;
      if (bit_cnt_q == BIT_CNT_W'(`SPI_WB_CMD_END - 1)) begin
        cmd_q <= rx_word[7:0];
      end
      if (bit_cnt_q == BIT_CNT_W'(`SPI_WB_ADDR_END - 1)) begin
        adr_q.raw <= rx_word;
      end
      if (bit_cnt_q == BIT_CNT_W'(`SPI_WB_DATA_END - 1)) begin
        dat_w_q <= rx_word;
      end
    end
  end

  // ----------------------------------------------------------------------
  // bus cycle
  // ----------------------------------------------------------------------
  assign resp = stb_q && (m_bus.ack || m_bus.err);

  always_comb begin
    status         = '0;
    status.ack     = m_bus.ack;
    status.err     = m_bus.err;
    // an error this late can only be the watchdog.
    status.timeout = m_bus.err && (wait_q >= WAIT_W'(`SPI_WB_TIMEOUT));
  end

  always_ff @(posedge sys_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      stb_q  <= 1'b0;
      wait_q <= '0;
    end else if (launch) begin
      stb_q  <= 1'b1;
      wait_q <= '0;
    end else if (resp) begin
      stb_q  <= 1'b0;     // drop after ack or err.
    end else if (stb_q) begin
      wait_q <= wait_q + 1'b1;
    end
  end

  assign m_bus.cyc   = stb_q;
  assign m_bus.stb   = stb_q;
  assign m_bus.we    = cmd_q[7];
  assign m_bus.sel   = cmd_q[3:0];
  assign m_bus.adr   = adr_q;
  assign m_bus.dat_w = dat_w_q;

  // ----------------------------------------------------------------------
  // transmit side
  // ----------------------------------------------------------------------
  always_ff @(posedge sys_clk) begin
    if (resp) begin
      tx_sr_q <= {status, m_bus.dat_r};
    end else if (sclk_fall && !cs_n_s && (bit_cnt_q > tx_start)) begin
      tx_sr_q <= {tx_sr_q[`SPI_WB_TX_W-2:0], 1'b0};
    end
  end

  assign spi_miso_o = (!cs_n_s && (bit_cnt_q >= tx_start)) ? tx_sr_q[`SPI_WB_TX_W-1] : 1'b0;

endmodule

// File: source/wb_if.sv
`timescale 1ns/10ps

interface wb_if;

  logic                 cyc;
  logic                 stb;
  logic                 we;
  logic [3:0]           sel;
  spi_wb_pkg::wb_addr_u adr;
  logic [31:0]          dat_w;
  logic [31:0]          dat_r;
  logic                 ack;
  logic                 err;

  modport initiator (
    output cyc, stb, we, sel, adr, dat_w,
    input  dat_r, ack, err
  );

  modport target (
    input  cyc, stb, we, sel, adr, dat_w,
    output dat_r, ack, err
  );

  // response tap for the collector.
  modport observer (
    input stb, dat_r, ack, err
  );

endinterface

// File: source/spi_wb_pkg.sv
`include "spi_wb_macros.svh"

package spi_wb_pkg;

  // word address as seen by the decoder and the slots.
  typedef struct packed {
    logic [`SPI_WB_PAD_W-1:0]  pad;      // must be zero for a hit.
    logic [`SPI_WB_SLOT_W-1:0] slot;
    logic [`SPI_WB_REG_W-1:0]  reg_idx;
  } wb_addr_fields_t;

  // one word seen raw or split.
  typedef union packed {
    logic [31:0]     raw;
    wb_addr_fields_t f;
  } wb_addr_u;

  // status byte returned on miso.
  typedef struct packed {
    logic [4:0] rsvd;     // always zero.
    logic       timeout;
    logic       err;
    logic       ack;
  } wb_status_t;

endpackage

// File: source/spi_wb_macros.svh
`ifndef SPI_WB_MACROS_SVH
`define SPI_WB_MACROS_SVH

// ----------------------------------------------------------------------
// bus decode
// ----------------------------------------------------------------------
`define SPI_WB_N_SLOTS   4
`define SPI_WB_TIMEOUT   16
`define SPI_WB_SLOT_W    4
`define SPI_WB_REG_W     8
`define SPI_WB_PAD_W     (32 - `SPI_WB_SLOT_W - `SPI_WB_REG_W)

// ----------------------------------------------------------------------
// frame layout in sclk bits
// ----------------------------------------------------------------------
`define SPI_WB_CMD_END   8
`define SPI_WB_ADDR_END  40
`define SPI_WB_DATA_END  72
`define SPI_WB_TX_W      40

`endif
